// ==== Bender.yml ====
package:
  name: psx_host_glue

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - hw/psx_host_pkg.sv
      - hw/psx_video_pkg.sv
      - hw/download_region_decoder.sv
      - hw/download_write_engine.sv
      - hw/video_config_regs.sv
      - hw/psx_host_glue_top.sv

  # simulation only
  - target: test
    files:
      - testbench/psx_host_glue_properties.sv
      - testbench/tb_psx_host_glue.sv

// ==== hw/download_region_decoder.sv ====
// download region decoder with executable load pulse, disc size capture and core reset
`timescale 1ns/10ps
`default_nettype none

module download_region_decoder (
	input  wire                     clk_1x,
	input  wire                     rst_n,
	input  wire                     ioctl_download,
	input  psx_host_pkg::dl_index_t ioctl_index,
	input  psx_host_pkg::ram_addr_t ioctl_addr,
	input  wire                     osd_reset,
	output logic                    dl_bios,
	output logic                    dl_exe,
	output logic                    dl_cd,
	output logic                    load_exe,
	output psx_host_pkg::ram_addr_t cd_size,
	output logic                    core_reset
);

	localparam int CD_BITS = psx_host_pkg::IDX_CD_MASK_BITS;

	// next region levels from the live host signals
	logic bios_sel;
	logic exe_sel;
	logic cd_sel;
	// dl_exe one cycle late, for the falling edge
	logic dl_exe_q;

	assign bios_sel = ioctl_download && (ioctl_index == psx_host_pkg::IDX_BIOS);
	assign exe_sel  = ioctl_download && (ioctl_index == psx_host_pkg::IDX_EXE);
	// disc slot bits above the mask are ignored
	assign cd_sel   = ioctl_download &&
		(ioctl_index[CD_BITS-1:0] == psx_host_pkg::IDX_CD[CD_BITS-1:0]);

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			dl_bios  <= 1'b0;
			dl_exe   <= 1'b0;
			dl_cd    <= 1'b0;
			dl_exe_q <= 1'b0;
			load_exe <= 1'b0;
			cd_size  <= '0;
		end else begin
			dl_bios  <= bios_sel;
			dl_exe   <= exe_sel;
			dl_cd    <= cd_sel;
			dl_exe_q <= dl_exe;
			// single pulse once the executable is in memory
			load_exe <= dl_exe_q && !dl_exe;
			// last host address is the image size
			if (dl_cd && !cd_sel) begin
				cd_size <= ioctl_addr;
			end
		end
	end

	// core stays in reset for the whole download and during system reset
	assign core_reset = osd_reset || dl_bios || dl_exe || dl_cd || !rst_n;

endmodule

`default_nettype wire

// ==== hw/download_write_engine.sv ====
// download write engine: half word packing, region offset, memory write ports and host wait
`timescale 1ns/10ps
`default_nettype none

module download_write_engine (
	input  wire                       clk_1x,
	input  wire                       rst_n,
	input  wire                       dl_bios,
	input  wire                       dl_exe,
	input  wire                       dl_cd,
	input  wire                       ioctl_wr,
	input  psx_host_pkg::ram_addr_t   ioctl_addr,
	input  psx_host_pkg::host_half_t  ioctl_dout,
	output logic                      ioctl_wait,
	input  wire                       core_wr_req,
	input  psx_host_pkg::ram_addr_t   core_wr_addr,
	input  psx_host_pkg::ram_word_t   core_wr_data,
	input  psx_host_pkg::ram_be_t     core_wr_be,
	output logic                      main_wr_req,
	output psx_host_pkg::ram_addr_t   main_wr_addr,
	output psx_host_pkg::ram_word_t   main_wr_data,
	output psx_host_pkg::ram_be_t     main_wr_be,
	input  wire                       main_wr_ack,
	output logic                      cd_wr_req,
	output psx_host_pkg::ram_addr_t   cd_wr_addr,
	output psx_host_pkg::ram_word_t   cd_wr_data,
	input  wire                       cd_wr_ack
);

	// ========================================================================
	// region decode
	// ========================================================================

	logic                     dl_active;
	// BIOS or executable owns the main port
	logic                     dl_main;
	psx_host_pkg::ram_addr_t  region_base;
	// ack of whichever port the download writes to
	logic                     wr_ack;

	assign dl_active = dl_bios || dl_exe || dl_cd;
	assign dl_main   = dl_bios || dl_exe;
	assign wr_ack    = dl_cd ? cd_wr_ack : main_wr_ack;

	always_comb begin
		region_base = '0;
		if (dl_bios) begin
			region_base = psx_host_pkg::BIOS_BASE;
		end else if (dl_exe) begin
			region_base = psx_host_pkg::EXE_BASE;
		end
		// disc image lands at the raw address
	end

	// ========================================================================
	// word assembly
	// ========================================================================

	psx_host_pkg::ram_addr_t  wr_addr;
	psx_host_pkg::host_half_t wr_lo;
	psx_host_pkg::host_half_t wr_hi;
	psx_host_pkg::ram_word_t  wr_word;
	logic                     wr_pulse;
	logic                     wait_q;

	assign wr_word = {wr_hi, wr_lo};

	// even half carries the word address, odd half completes it
	always_ff @(posedge clk_1x) begin
		if (dl_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				wr_lo   <= ioctl_dout;
				wr_addr <= ioctl_addr + region_base;
			end else begin
				wr_hi <= ioctl_dout;
			end
		end
	end

	// one write in flight, host held until the memory acks
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			wr_pulse <= 1'b0;
			wait_q   <= 1'b0;
		end else begin
			wr_pulse <= 1'b0;
			if (!dl_active) begin
				wait_q <= 1'b0;
			end else begin
				if (ioctl_wr && ioctl_addr[1]) begin
					wr_pulse <= 1'b1;
					wait_q   <= 1'b1;
				end
				if (wr_ack) begin
					wait_q <= 1'b0;
				end
			end
		end
	end

	// drop wait as soon as the region goes away
	assign ioctl_wait = wait_q && dl_active;

	// ========================================================================
	// port muxing
	// ========================================================================

	// core gets the main port back outside BIOS and exe loads
	assign main_wr_req  = dl_main ? wr_pulse : core_wr_req;
	assign main_wr_addr = dl_main ? wr_addr : core_wr_addr;
	assign main_wr_data = dl_main ? wr_word : core_wr_data;
	assign main_wr_be   = dl_main ? psx_host_pkg::BE_ALL : core_wr_be;

	// disc memory only sees image writes
	assign cd_wr_req  = dl_cd && wr_pulse;
	assign cd_wr_addr = wr_addr;
	assign cd_wr_data = wr_word;

endmodule

`default_nettype wire

// ==== hw/psx_host_glue_top.sv ====
// host glue top level with region decoder, download write engine and video registers
`timescale 1ns/10ps
`default_nettype none

module psx_host_glue_top (
	input  wire                        clk_1x,
	input  wire                        rst_n,
	// host download stream
	input  wire                        ioctl_download,
	input  psx_host_pkg::dl_index_t    ioctl_index,
	input  psx_host_pkg::ram_addr_t    ioctl_addr,
	input  wire                        ioctl_wr,
	input  psx_host_pkg::host_half_t   ioctl_dout,
	output logic                       ioctl_wait,
	// core control
	output logic                       load_exe,
	output psx_host_pkg::ram_addr_t    cd_size,
	output logic                       core_reset,
	// core writes
	input  wire                        core_wr_req,
	input  psx_host_pkg::ram_addr_t    core_wr_addr,
	input  psx_host_pkg::ram_word_t    core_wr_data,
	input  psx_host_pkg::ram_be_t      core_wr_be,
	// main memory write port
	output logic                       main_wr_req,
	output psx_host_pkg::ram_addr_t    main_wr_addr,
	output psx_host_pkg::ram_word_t    main_wr_data,
	output psx_host_pkg::ram_be_t      main_wr_be,
	input  wire                        main_wr_ack,
	// disc memory write port
	output logic                       cd_wr_req,
	output psx_host_pkg::ram_addr_t    cd_wr_addr,
	output psx_host_pkg::ram_word_t    cd_wr_data,
	input  wire                        cd_wr_ack,
	// OSD status and display geometry
	input  psx_video_pkg::status_t     status,
	input  wire                        video_interlace,
	input  psx_video_pkg::fb_dim_t     display_width,
	input  psx_video_pkg::fb_dim_t     display_height,
	input  psx_video_pkg::disp_off_x_t display_off_x,
	input  psx_video_pkg::disp_off_y_t display_off_y,
	// framebuffer and scaler config
	output logic                       fb_en,
	output psx_video_pkg::fb_format_t  fb_format,
	output psx_video_pkg::fb_addr_t    fb_base,
	output psx_video_pkg::fb_dim_t     fb_width,
	output psx_video_pkg::fb_dim_t     fb_height,
	output psx_video_pkg::fb_stride_t  fb_stride,
	output logic                       vga_f1,
	output logic [1:0]                 vga_sl,
	output psx_video_pkg::fb_dim_t     arx,
	output psx_video_pkg::fb_dim_t     ary,
	output logic [1:0]                 scale_mode
);

	// registered region levels, decoder to engine
	logic dl_bios;
	logic dl_exe;
	logic dl_cd;

	download_region_decoder u_decoder (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.osd_reset      (status[psx_video_pkg::ST_RESET]),
		.dl_bios        (dl_bios),
		.dl_exe         (dl_exe),
		.dl_cd          (dl_cd),
		.load_exe       (load_exe),
		.cd_size        (cd_size),
		.core_reset     (core_reset)
	);

	download_write_engine u_engine (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.dl_bios      (dl_bios),
		.dl_exe       (dl_exe),
		.dl_cd        (dl_cd),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ioctl_wait   (ioctl_wait),
		.core_wr_req  (core_wr_req),
		.core_wr_addr (core_wr_addr),
		.core_wr_data (core_wr_data),
		.core_wr_be   (core_wr_be),
		.main_wr_req  (main_wr_req),
		.main_wr_addr (main_wr_addr),
		.main_wr_data (main_wr_data),
		.main_wr_be   (main_wr_be),
		.main_wr_ack  (main_wr_ack),
		.cd_wr_req    (cd_wr_req),
		.cd_wr_addr   (cd_wr_addr),
		.cd_wr_data   (cd_wr_data),
		.cd_wr_ack    (cd_wr_ack)
	);

	video_config_regs u_video_cfg (
		.clk_1x          (clk_1x),
		.rst_n           (rst_n),
		.status          (status),
		.video_interlace (video_interlace),
		.display_width   (display_width),
		.display_height  (display_height),
		.display_off_x   (display_off_x),
		.display_off_y   (display_off_y),
		.fb_en           (fb_en),
		.fb_format       (fb_format),
		.fb_base         (fb_base),
		.fb_width        (fb_width),
		.fb_height       (fb_height),
		.fb_stride       (fb_stride),
		.vga_f1          (vga_f1),
		.vga_sl          (vga_sl),
		.arx             (arx),
		.ary             (ary),
		.scale_mode      (scale_mode)
	);

endmodule

`default_nettype wire

// ==== hw/psx_host_pkg.sv ====
// host download region codes, region base offsets and memory word types
`default_nettype none

package psx_host_pkg;

	// ========================================================================
	// memory side types
	// ========================================================================

	// byte address into main or disc memory
	typedef logic [26:0] ram_addr_t;
	typedef logic [31:0] ram_word_t;
	typedef logic [3:0]  ram_be_t;

	// ========================================================================
	// host stream types
	// ========================================================================

	typedef logic [15:0] host_half_t;
	typedef logic [7:0]  dl_index_t;

	// download index codes, as sent with ioctl_index
	localparam dl_index_t IDX_BIOS = 8'd0;
	localparam dl_index_t IDX_EXE  = 8'd1;
	localparam dl_index_t IDX_CD   = 8'd2;

	// disc index only checked on the low bits, upper bits carry the drive slot
	localparam int IDX_CD_MASK_BITS = 6;

	// region offsets added to the host byte address
	localparam ram_addr_t BIOS_BASE = 27'd2097152;
	localparam ram_addr_t EXE_BASE  = 27'd4194304;

	// download words are always full width
	localparam ram_be_t BE_ALL = 4'b1111;

endpackage

`default_nettype wire

// ==== hw/psx_video_pkg.sv ====
// framebuffer, aspect and status bit constants plus the video types
`default_nettype none

package psx_video_pkg;

	// ========================================================================
	// video types
	// ========================================================================

	// OSD status word
	typedef logic [63:0] status_t;
	typedef logic [11:0] fb_dim_t;
	typedef logic [31:0] fb_addr_t;
	typedef logic [4:0]  fb_format_t;
	typedef logic [13:0] fb_stride_t;
	// display window offsets from the core
	typedef logic [9:0]  disp_off_x_t;
	typedef logic [8:0]  disp_off_y_t;

	// framebuffer placement in DDR, one VRAM line per pitch
	localparam fb_addr_t   FB_BASE_ADDR    = 32'h3000_0000;
	localparam fb_stride_t FB_STRIDE_BYTES = 14'd2048;

	// 16bpp 1555 and 24bpp RGB
	localparam fb_format_t FMT_RGB16 = 5'b01100;
	localparam fb_format_t FMT_RGB24 = 5'b00101;

	// full VRAM view
	localparam fb_dim_t VIEWER_W = 12'd1024;
	localparam fb_dim_t VIEWER_H = 12'd512;

	// default aspect, 4:3 normally and 2:1 for the VRAM viewer
	localparam fb_dim_t AR_STD_X    = 12'd4;
	localparam fb_dim_t AR_STD_Y    = 12'd3;
	localparam fb_dim_t AR_VIEWER_X = 12'd2;
	localparam fb_dim_t AR_VIEWER_Y = 12'd1;

	// ========================================================================
	// status word bit positions
	// ========================================================================

	localparam int ST_RESET         = 0;
	// 3 bit scale field
	localparam int ST_SCALE_LO      = 2;
	localparam int ST_COLOR24       = 10;
	localparam int ST_VIEWER        = 11;
	localparam int ST_FB_EN         = 14;
	// 2 bit aspect field
	localparam int ST_AR_LO         = 32;
	localparam int ST_SCALE_MODE_LO = 34;

endpackage

`default_nettype wire

// ==== hw/video_config_regs.sv ====
// video and framebuffer configuration registers decoded from status and display geometry
`timescale 1ns/10ps
`default_nettype none

module video_config_regs (
	input  wire                        clk_1x,
	input  wire                        rst_n,
	input  psx_video_pkg::status_t     status,
	input  wire                        video_interlace,
	input  psx_video_pkg::fb_dim_t     display_width,
	input  psx_video_pkg::fb_dim_t     display_height,
	input  psx_video_pkg::disp_off_x_t display_off_x,
	input  psx_video_pkg::disp_off_y_t display_off_y,
	output logic                       fb_en,
	output psx_video_pkg::fb_format_t  fb_format,
	output psx_video_pkg::fb_addr_t    fb_base,
	output psx_video_pkg::fb_dim_t     fb_width,
	output psx_video_pkg::fb_dim_t     fb_height,
	output psx_video_pkg::fb_stride_t  fb_stride,
	output logic                       vga_f1,
	output logic [1:0]                 vga_sl,
	output psx_video_pkg::fb_dim_t     arx,
	output psx_video_pkg::fb_dim_t     ary,
	output logic [1:0]                 scale_mode
);

	// ========================================================================
	// status field decode
	// ========================================================================

	logic                    viewer;
	logic [2:0]              scale;
	logic [1:0]              sl;
	logic [1:0]              ar;
	psx_video_pkg::fb_addr_t win_base;

	assign viewer = status[psx_video_pkg::ST_VIEWER];
	assign scale  = status[psx_video_pkg::ST_SCALE_LO +: 3];
	assign ar     = status[psx_video_pkg::ST_AR_LO +: 2];

	// scale 0 is plain output, others map one step down
	assign sl = (scale != 3'd0) ? 2'(scale - 3'd1) : 2'd0;

	// display window start, 2 bytes per pixel and one pitch per line
	assign win_base = psx_video_pkg::FB_BASE_ADDR
		+ (psx_video_pkg::fb_addr_t'(display_off_x) << 1)
		+ psx_video_pkg::fb_addr_t'(display_off_y)
		* psx_video_pkg::fb_addr_t'(psx_video_pkg::FB_STRIDE_BYTES);

	// ========================================================================
	// registered outputs
	// ========================================================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			fb_en  <= 1'b0;
			vga_f1 <= 1'b0;
		end else begin
			fb_en  <= status[psx_video_pkg::ST_FB_EN];
			// framebuffer path is progressive
			vga_f1 <= status[psx_video_pkg::ST_FB_EN] ? 1'b0 : video_interlace;
		end
	end

	always_ff @(posedge clk_1x) begin
		fb_format <= status[psx_video_pkg::ST_COLOR24] ?
			psx_video_pkg::FMT_RGB24 : psx_video_pkg::FMT_RGB16;
		fb_stride <= psx_video_pkg::FB_STRIDE_BYTES;
		// viewer shows all of VRAM, else just the visible window
		if (viewer) begin
			fb_base   <= psx_video_pkg::FB_BASE_ADDR;
			fb_width  <= psx_video_pkg::VIEWER_W;
			fb_height <= psx_video_pkg::VIEWER_H;
		end else begin
			fb_base   <= win_base;
			fb_width  <= display_width;
			fb_height <= display_height;
		end
		vga_sl     <= sl;
		scale_mode <= status[psx_video_pkg::ST_SCALE_MODE_LO +: 2];
		// aspect 0 is original, otherwise custom ARC slot index
		if (ar == 2'd0) begin
			arx <= viewer ? psx_video_pkg::AR_VIEWER_X : psx_video_pkg::AR_STD_X;
			ary <= viewer ? psx_video_pkg::AR_VIEWER_Y : psx_video_pkg::AR_STD_Y;
		end else begin
			arx <= psx_video_pkg::fb_dim_t'(ar) - 12'd1;
			ary <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/psx_host_pkg.sv
hw/psx_video_pkg.sv
hw/download_region_decoder.sv
hw/download_write_engine.sv
hw/video_config_regs.sv
hw/psx_host_glue_top.sv
testbench/psx_host_glue_properties.sv
testbench/tb_psx_host_glue.sv

// ==== testbench/psx_host_glue_properties.sv ====
// concurrent checks on download write pulses, host back-pressure, load pulse, core reset and fb_en
`timescale 1ns/10ps
`default_nettype none

module psx_host_glue_properties (
	input wire clk_1x,
	input wire rst_n,
	input wire dl_bios,
	input wire dl_exe,
	input wire dl_cd,
	input wire ioctl_wait,
	input wire main_wr_req,
	input wire cd_wr_req,
	input wire load_exe,
	input wire core_reset,
	input wire fb_en
);

	// failed property count, watched by the testbench
	int violations = 0;

	// download write on either port
	logic dl_req;

	assign dl_req = ((dl_bios || dl_exe) && main_wr_req) || cd_wr_req;

	main_req_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		(dl_bios || dl_exe) && main_wr_req |=> !main_wr_req)
		else begin
			violations++;
			$error("main port download request held too long");
		end

	cd_req_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cd_wr_req |=> !cd_wr_req)
		else begin
			violations++;
			$error("disc port request held too long");
		end

	// host held off for the whole write
	req_raises_wait: assert property (@(posedge clk_1x) disable iff (!rst_n)
		dl_req |-> ioctl_wait)
		else begin
			violations++;
			$error("download write without host wait");
		end

	// one write outstanding, nothing new until the host is released
	no_req_while_wait: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait && $past(ioctl_wait) |-> !dl_req)
		else begin
			violations++;
			$error("new download write while the previous one is pending");
		end

	load_exe_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		load_exe |=> !load_exe)
		else begin
			violations++;
			$error("load_exe longer than one cycle");
		end

	reset_while_loading: assert property (@(posedge clk_1x) disable iff (!rst_n)
		(dl_bios || dl_exe || dl_cd) |-> core_reset)
		else begin
			violations++;
			$error("core not in reset during a download");
		end

	// no disable here, the reset value itself is checked
	fb_off_after_reset: assert property (@(posedge clk_1x)
		!rst_n |=> !fb_en)
		else begin
			violations++;
			$error("fb_en set right after reset");
		end

endmodule

bind psx_host_glue_top psx_host_glue_properties u_props (
	.clk_1x      (clk_1x),
	.rst_n       (rst_n),
	.dl_bios     (dl_bios),
	.dl_exe      (dl_exe),
	.dl_cd       (dl_cd),
	.ioctl_wait  (ioctl_wait),
	.main_wr_req (main_wr_req),
	.cd_wr_req   (cd_wr_req),
	.load_exe    (load_exe),
	.core_reset  (core_reset),
	.fb_en       (fb_en)
);

`default_nettype wire

// ==== testbench/tb_psx_host_glue.sv ====
// host glue testbench with stimulus, memory ack model, reference decode, compare and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_psx_host_glue;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int N_BIOS      = 16;
	localparam int N_EXE       = 12;
	localparam int N_CD        = 20;
	// video and core pass-through steps
	localparam int N_STEPS     = 30;
	localparam int WATCHDOG_CYCLES = (N_BIOS + N_EXE + N_CD) * 8 + 200;

	typedef enum {MODE_IDLE, MODE_BIOS, MODE_EXE, MODE_CD} mode_t;
	// fb_en, format, base, width, height, stride, f1, sl, arx, ary, scale_mode
	typedef logic [104:0] video_vec_t;
	// address then word of one expected download write
	typedef logic [58:0] dl_write_t;

	logic                       clk_1x;
	logic                       rst_n;
	logic                       ioctl_download;
	psx_host_pkg::dl_index_t    ioctl_index;
	psx_host_pkg::ram_addr_t    ioctl_addr;
	logic                       ioctl_wr;
	psx_host_pkg::host_half_t   ioctl_dout;
	logic                       ioctl_wait;
	logic                       load_exe;
	psx_host_pkg::ram_addr_t    cd_size;
	logic                       core_reset;
	logic                       core_wr_req;
	psx_host_pkg::ram_addr_t    core_wr_addr;
	psx_host_pkg::ram_word_t    core_wr_data;
	psx_host_pkg::ram_be_t      core_wr_be;
	logic                       main_wr_req;
	psx_host_pkg::ram_addr_t    main_wr_addr;
	psx_host_pkg::ram_word_t    main_wr_data;
	psx_host_pkg::ram_be_t      main_wr_be;
	logic                       main_wr_ack;
	logic                       cd_wr_req;
	psx_host_pkg::ram_addr_t    cd_wr_addr;
	psx_host_pkg::ram_word_t    cd_wr_data;
	logic                       cd_wr_ack;
	psx_video_pkg::status_t     status;
	logic                       video_interlace;
	psx_video_pkg::fb_dim_t     display_width;
	psx_video_pkg::fb_dim_t     display_height;
	psx_video_pkg::disp_off_x_t display_off_x;
	psx_video_pkg::disp_off_y_t display_off_y;
	logic                       fb_en;
	psx_video_pkg::fb_format_t  fb_format;
	psx_video_pkg::fb_addr_t    fb_base;
	psx_video_pkg::fb_dim_t     fb_width;
	psx_video_pkg::fb_dim_t     fb_height;
	psx_video_pkg::fb_stride_t  fb_stride;
	logic                       vga_f1;
	logic [1:0]                 vga_sl;
	psx_video_pkg::fb_dim_t     arx;
	psx_video_pkg::fb_dim_t     ary;
	logic [1:0]                 scale_mode;

	// scoreboard state
	mode_t       mode;
	dl_write_t   main_q[$];
	dl_write_t   cd_q[$];
	dl_write_t   exp_main;
	dl_write_t   exp_cd;
	video_vec_t  exp_vid;
	int          main_count;
	int          cd_count;
	int          load_count;
	logic        main_busy;
	logic        cd_busy;
	logic        core_active;
	int          main_delay;
	int          cd_delay;

	// video inputs as seen by the DUT at the last edge
	logic                       vid_valid;
	psx_video_pkg::status_t     samp_status;
	logic                       samp_interlace;
	psx_video_pkg::fb_dim_t     samp_width;
	psx_video_pkg::fb_dim_t     samp_height;
	psx_video_pkg::disp_off_x_t samp_off_x;
	psx_video_pkg::disp_off_y_t samp_off_y;
	// download level as registered by the region decoder
	logic                       samp_download;

	psx_host_glue_top u_dut (.*);

	initial clk_1x = 1'b0;
	always #(CLK_PERIOD / 2) clk_1x = ~clk_1x;

	// ========================================================================
	// reporting and reference decode
	// ========================================================================

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic report_mismatch(input string what);
		$display("Error at time %0t: %s", $time, what);
		abort_run();
	endtask

	// region offset on the host byte address, disc stays raw
	function automatic psx_host_pkg::ram_addr_t ref_addr(input mode_t m,
			input psx_host_pkg::ram_addr_t a);
		case (m)
			MODE_BIOS: return a + psx_host_pkg::BIOS_BASE;
			MODE_EXE:  return a + psx_host_pkg::EXE_BASE;
			default:   return a;
		endcase
	endfunction

	function automatic video_vec_t ref_video(input psx_video_pkg::status_t s, input logic il,
			input psx_video_pkg::fb_dim_t w, input psx_video_pkg::fb_dim_t h,
			input psx_video_pkg::disp_off_x_t ox, input psx_video_pkg::disp_off_y_t oy);
		logic                      viewer;
		logic [2:0]                scale;
		logic [1:0]                ar;
		logic [1:0]                sl;
		psx_video_pkg::fb_format_t fmt;
		psx_video_pkg::fb_addr_t   base;
		psx_video_pkg::fb_dim_t    ew;
		psx_video_pkg::fb_dim_t    eh;
		psx_video_pkg::fb_dim_t    ax;
		psx_video_pkg::fb_dim_t    ay;
		viewer = s[psx_video_pkg::ST_VIEWER];
		scale  = s[psx_video_pkg::ST_SCALE_LO +: 3];
		ar     = s[psx_video_pkg::ST_AR_LO +: 2];
		fmt    = s[psx_video_pkg::ST_COLOR24] ? psx_video_pkg::FMT_RGB24 : psx_video_pkg::FMT_RGB16;
		if (viewer) begin
			base = psx_video_pkg::FB_BASE_ADDR;
			ew   = 12'd1024;
			eh   = 12'd512;
		end else begin
			// two bytes per pixel, 2048 byte lines
			base = psx_video_pkg::FB_BASE_ADDR + 32'(ox) * 32'd2 + 32'(oy) * 32'd2048;
			ew   = w;
			eh   = h;
		end
		sl = (scale == 3'd0) ? 2'd0 : 2'(scale - 3'd1);
		if (ar == 2'd0) begin
			ax = viewer ? 12'd2 : 12'd4;
			ay = viewer ? 12'd1 : 12'd3;
		end else begin
			ax = psx_video_pkg::fb_dim_t'(ar) - 12'd1;
			ay = 12'd0;
		end
		return {s[psx_video_pkg::ST_FB_EN], fmt, base, ew, eh, 14'd2048,
			s[psx_video_pkg::ST_FB_EN] ? 1'b0 : il, sl, ax, ay,
			s[psx_video_pkg::ST_SCALE_MODE_LO +: 2]};
	endfunction

	// ========================================================================
	// host stimulus
	// ========================================================================

	task automatic wait_drive_slot();
		@(posedge clk_1x);
		#DRIVE_DELAY;
	endtask

	task automatic send_half(input psx_host_pkg::ram_addr_t a, input psx_host_pkg::host_half_t d);
		while (ioctl_wait) begin
			wait_drive_slot();
		end
		ioctl_wr   = 1'b1;
		ioctl_addr = a;
		ioctl_dout = d;
		wait_drive_slot();
		ioctl_wr = 1'b0;
	endtask

	task automatic run_download(input mode_t m, input psx_host_pkg::dl_index_t idx, input int n);
		psx_host_pkg::ram_addr_t  start;
		psx_host_pkg::ram_addr_t  a;
		psx_host_pkg::host_half_t lo;
		psx_host_pkg::host_half_t hi;
		start      = psx_host_pkg::ram_addr_t'($urandom & 32'h000f_fffc);
		a          = start;
		mode       = m;
		main_count = 0;
		cd_count   = 0;
		load_count = 0;
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		repeat (2) wait_drive_slot();
		for (int i = 0; i < n; i++) begin
			a  = start + psx_host_pkg::ram_addr_t'(i * 4);
			lo = psx_host_pkg::host_half_t'($urandom);
			hi = psx_host_pkg::host_half_t'($urandom);
			if (m == MODE_CD) begin
				cd_q.push_back({ref_addr(m, a), hi, lo});
			end else begin
				main_q.push_back({ref_addr(m, a), hi, lo});
			end
			send_half(a, lo);
			send_half(a + 27'd2, hi);
		end
		while (ioctl_wait) begin
			wait_drive_slot();
		end
		ioctl_download = 1'b0;
		// load pulse lands two edges after the fall
		repeat (4) wait_drive_slot();
		assert (((m == MODE_CD) ? cd_count : main_count) == n)
			else report_mismatch($sformatf("%0d writes seen, expected %0d",
				(m == MODE_CD) ? cd_count : main_count, n));
		assert (load_count == ((m == MODE_EXE) ? 1 : 0))
			else report_mismatch($sformatf("%0d load_exe pulses after download", load_count));
		if (m == MODE_CD) begin
			assert (cd_size == a + 27'd2)
				else report_mismatch($sformatf("cd_size %h, expected %h", cd_size, a + 27'd2));
		end
		mode = MODE_IDLE;
	endtask

	// ========================================================================
	// core traffic and memory ack model
	// ========================================================================

	always @(posedge clk_1x) begin
		#DRIVE_DELAY;
		if (core_active) begin
			core_wr_req  = ($urandom % 2) == 1;
			core_wr_addr = psx_host_pkg::ram_addr_t'($urandom);
			core_wr_data = $urandom;
			core_wr_be   = psx_host_pkg::ram_be_t'($urandom);
		end else begin
			core_wr_req = 1'b0;
		end
	end

	// ack one to four cycles after the request
	always begin
		@(negedge clk_1x);
		if (rst_n && main_wr_req) begin
			main_delay = 1 + ($urandom % 4);
			repeat (main_delay) @(posedge clk_1x);
			#DRIVE_DELAY main_wr_ack = 1'b1;
			@(posedge clk_1x);
			#DRIVE_DELAY main_wr_ack = 1'b0;
		end
	end

	always begin
		@(negedge clk_1x);
		if (rst_n && cd_wr_req) begin
			cd_delay = 1 + ($urandom % 4);
			repeat (cd_delay) @(posedge clk_1x);
			#DRIVE_DELAY cd_wr_ack = 1'b1;
			@(posedge clk_1x);
			#DRIVE_DELAY cd_wr_ack = 1'b0;
		end
	end

	// ========================================================================
	// compare, mid cycle
	// ========================================================================

	always @(posedge clk_1x) begin
		vid_valid      <= rst_n;
		samp_status    <= status;
		samp_interlace <= video_interlace;
		samp_width     <= display_width;
		samp_height    <= display_height;
		samp_off_x     <= display_off_x;
		samp_off_y     <= display_off_y;
		samp_download  <= ioctl_download;
	end

	always @(negedge clk_1x) begin
		// core held in reset by system reset, OSD reset or any download
		assert (core_reset == (!rst_n || status[psx_video_pkg::ST_RESET] || samp_download))
			else report_mismatch($sformatf("core_reset %b, expected %b", core_reset,
				!rst_n || status[psx_video_pkg::ST_RESET] || samp_download));
		if (rst_n) begin
			if (mode == MODE_BIOS || mode == MODE_EXE) begin
				if (main_wr_req) begin
					assert (!main_busy) else report_mismatch("main write before previous ack");
					assert (main_q.size() > 0) else report_mismatch("unexpected main port write");
					exp_main = main_q.pop_front();
					assert ({main_wr_addr, main_wr_data, main_wr_be} ==
						{exp_main, psx_host_pkg::BE_ALL})
						else report_mismatch($sformatf("main write %h %h %h, expected %h %h",
							main_wr_addr, main_wr_data, main_wr_be, exp_main[58:32],
							exp_main[31:0]));
					main_busy = 1'b1;
					main_count++;
				end
			end else begin
				// core owns the main port
				assert ({main_wr_req, main_wr_addr, main_wr_data, main_wr_be} ==
					{core_wr_req, core_wr_addr, core_wr_data, core_wr_be})
					else report_mismatch("main port differs from core write");
			end
			if (main_wr_ack) begin
				main_busy = 1'b0;
			end
			if (cd_wr_req) begin
				assert (mode == MODE_CD) else report_mismatch("disc write outside disc download");
				assert (!cd_busy) else report_mismatch("disc write before previous ack");
				assert (cd_q.size() > 0) else report_mismatch("unexpected disc port write");
				exp_cd = cd_q.pop_front();
				assert ({cd_wr_addr, cd_wr_data} == exp_cd)
					else report_mismatch($sformatf("disc write %h %h, expected %h %h",
						cd_wr_addr, cd_wr_data, exp_cd[58:32], exp_cd[31:0]));
				cd_busy = 1'b1;
				cd_count++;
			end
			if (cd_wr_ack) begin
				cd_busy = 1'b0;
			end
			if (load_exe) begin
				load_count++;
			end
		end
		if (vid_valid) begin
			exp_vid = ref_video(samp_status, samp_interlace, samp_width, samp_height,
				samp_off_x, samp_off_y);
			assert ({fb_en, fb_format, fb_base, fb_width, fb_height, fb_stride, vga_f1, vga_sl,
				arx, ary, scale_mode} === exp_vid)
				else report_mismatch($sformatf("video outputs %h, expected %h",
					{fb_en, fb_format, fb_base, fb_width, fb_height, fb_stride, vga_f1,
					vga_sl, arx, ary, scale_mode}, exp_vid));
		end
		// bound concurrent checks
		assert (u_dut.u_props.violations == 0)
			else begin
				$display("Concurrent property check failed at time %0t", $time);
				abort_run();
			end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_1x);
		$display("Watchdog expired at time %0t before the tests completed", $time);
		abort_run();
	end

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		void'($urandom(32'hbbc5_c80f));
		rst_n           = 1'b0;
		ioctl_download  = 1'b0;
		ioctl_index     = '0;
		ioctl_addr      = '0;
		ioctl_wr        = 1'b0;
		ioctl_dout      = '0;
		core_wr_req     = 1'b0;
		core_wr_addr    = '0;
		core_wr_data    = '0;
		core_wr_be      = '0;
		main_wr_ack     = 1'b0;
		cd_wr_ack       = 1'b0;
		status          = '0;
		video_interlace = 1'b0;
		display_width   = '0;
		display_height  = '0;
		display_off_x   = '0;
		display_off_y   = '0;
		mode            = MODE_IDLE;
		main_busy       = 1'b0;
		cd_busy         = 1'b0;
		core_active     = 1'b0;
		main_count      = 0;
		cd_count        = 0;
		load_count      = 0;
		repeat (5) @(posedge clk_1x);
		#DRIVE_DELAY rst_n = 1'b1;
		// random status words and display geometry
		repeat (N_STEPS) begin
			wait_drive_slot();
			status          = {$urandom, $urandom};
			video_interlace = ($urandom % 2) == 1;
			display_width   = psx_video_pkg::fb_dim_t'($urandom);
			display_height  = psx_video_pkg::fb_dim_t'($urandom);
			display_off_x   = psx_video_pkg::disp_off_x_t'($urandom);
			display_off_y   = psx_video_pkg::disp_off_y_t'($urandom);
		end
		wait_drive_slot();
		status = '0;
		run_download(MODE_BIOS, psx_host_pkg::IDX_BIOS, N_BIOS);
		run_download(MODE_EXE, psx_host_pkg::IDX_EXE, N_EXE);
		core_active = 1'b1;
		repeat (N_STEPS) wait_drive_slot();
		// drive slot 1 in the upper index bits, core keeps writing
		run_download(MODE_CD, 8'h42, N_CD);
		core_active = 1'b0;
		repeat (8) wait_drive_slot();
		if (u_dut.u_props.violations == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Concurrent property checks failed %0d times", u_dut.u_props.violations);
			abort_run();
		end
	end

endmodule

`default_nettype wire
